/* sim/filter_bank_trace.txt */
# test gap lane ref_id nbr_id ref_x ref_y ref_z nbr_x nbr_y nbr_z pass r2
# gap counts cycles since the previous line, 0 shares its cycle, ids in hex
2 3 0 00101 00102 1000 2000 -500 0 1000 0 1 2250000
2 2 2 00201 00202 -300 400 1200 100 -200 0 1 1960000
3 3 1 00301 00302 3072 0 0 0 0 0 0 9437184
3 2 3 00303 00304 0 -1536 0 0 1536 0 0 9437184
3 2 2 00305 00306 30000 -30000 20000 -30000 30000 -20000 0 8800000000
3 2 0 00307 00308 3071 0 0 0 0 0 1 9431041
4 3 0 00401 00402 100 50 -20 0 0 0 1 12900
4 0 1 00411 00412 200 50 -20 0 0 0 1 42900
4 0 2 00421 00422 300 50 -20 0 0 0 1 92900
4 0 3 00431 00432 400 50 -20 0 0 0 1 162900
4 1 0 00403 00404 100 100 -20 0 0 0 1 20400
4 1 1 00413 00414 200 100 -20 0 0 0 1 50400
4 0 2 00423 00424 300 100 -20 0 0 0 1 100400
4 0 3 00433 00434 400 100 -20 0 0 0 1 170400
4 0 0 00405 00406 100 100 -20 0 0 0 1 20400
5 3 0 00500 00600 10 20 30 0 0 0 1 1400
5 0 1 00510 00610 0 0 0 5 5 5 1 75
5 0 2 00520 00620 0 0 0 5 5 5 1 75
5 0 3 00530 00630 0 0 0 5 5 5 1 75
5 1 0 00501 00601 10 20 30 0 0 0 1 1400
5 0 1 00511 00611 0 0 0 5 5 5 1 75
5 0 2 00521 00621 0 0 0 5 5 5 1 75
5 0 3 00531 00631 0 0 0 5 5 5 1 75
5 1 0 00502 00602 10 20 30 0 0 0 1 1400
5 0 1 00512 00612 0 0 0 5 5 5 1 75
5 0 2 00522 00622 0 0 0 5 5 5 1 75
5 0 3 00532 00632 0 0 0 5 5 5 1 75
5 1 0 00503 00603 10 20 30 0 0 0 1 1400
5 0 1 00513 00613 0 0 0 5 5 5 1 75
5 0 2 00523 00623 0 0 0 5 5 5 1 75
5 0 3 00533 00633 0 0 0 5 5 5 1 75
5 1 0 00504 00604 10 20 30 0 0 0 1 1400
5 0 1 00514 00614 0 0 0 5 5 5 1 75
5 0 2 00524 00624 0 0 0 5 5 5 1 75
5 0 3 00534 00634 0 0 0 5 5 5 1 75
5 1 0 00505 00605 10 20 30 0 0 0 1 1400
5 1 0 00506 00606 10 20 30 0 0 0 1 1400
5 1 0 00507 00607 10 20 30 0 0 0 1 1400
5 1 0 00508 00608 10 20 30 0 0 0 1 1400
5 1 0 00509 00609 10 20 30 0 0 0 1 1400
5 1 0 0050a 0060a 10 20 30 0 0 0 1 1400
5 1 0 0050b 0060b 10 20 30 0 0 0 1 1400
5 1 0 0050c 0060c 10 20 30 0 0 0 1 1400
5 1 0 0050d 0060d 10 20 30 0 0 0 1 1400
5 1 0 0050e 0060e 10 20 30 0 0 0 1 1400
5 1 0 0050f 0060f 10 20 30 0 0 0 1 1400
5 1 0 00540 00640 10 20 30 0 0 0 1 1400
5 1 0 00541 00641 10 20 30 0 0 0 1 1400
5 1 0 00542 00642 10 20 30 0 0 0 1 1400

/* sim.f */
hdl/filter_bank_pkg.sv
hdl/pair_filter.sv
hdl/pair_buffer.sv
hdl/filter_arbiter.sv
hdl/filter_bank.sv
sim/clock_gen.sv
sim/filter_bank_tb.sv

/* sim/filter_bank_tb.sv */
//////////////////////////////
// Filter bank testbench
// Replays the pair trace into the lanes and scores every output
//////////////////////////////

module filter_bank_tb
	import filter_bank_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	logic clk;
	logic arst_n;
	logic [NUM_LANES-1:0] in_valid;
	pair_in_t in_pair [NUM_LANES];
	logic out_valid;
	pair_out_t out_pair;
	logic [NUM_LANES-1:0] back_pressure;

	// Trace contents
	int t_test[$];
	int t_gap[$];
	int t_lane[$];
	int t_pass[$];
	pair_in_t t_pair[$];
	pair_out_t t_exp[$];

	// Expected pairs per lane and the time each was driven
	pair_out_t exp_q [NUM_LANES][$];
	time exp_t [NUM_LANES][$];

	int errors = 0;
	int checks = 0;
	int tests = 0;
	bit loaded = 0;
	bit seen_out = 0;
	logic [NUM_LANES-1:0] bp_seen = '0;
	int full_run = 0;
	int hist [3];
	time last_out = 0;

	clock_gen u_clk (.clk(clk), .arst_n(arst_n));

	filter_bank DUT (
		.clk (clk),
		.arst_n (arst_n),
		.in_valid (in_valid),
		.in_pair (in_pair),
		.out_valid (out_valid),
		.out_pair (out_pair),
		.back_pressure (back_pressure)
	);

	//////////////////////////////
	// Trace loading
	//////////////////////////////
	task automatic load_trace();
		int fd;
		int cnt;
		int tst, gap, lane, pass;
		int rx, ry, rz, nx, ny, nz;
		longint r2, dx, dy, dz, calc;
		logic [ID_W-1:0] rid, nid;
		string line;
		pair_in_t p;
		pair_out_t e;
		fd = $fopen("sim/filter_bank_trace.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the trace file sim/filter_bank_trace.txt");
			errors++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() == 0 || line.getc(0) == "#")
					continue;
				cnt = $sscanf(line, "%d %d %d %h %h %d %d %d %d %d %d %d %d", tst, gap,
					lane, rid, nid, rx, ry, rz, nx, ny, nz, pass, r2);
				if (cnt != 13)
					continue;	// Blank or partial line
				dx = longint'(rx) - longint'(nx);
				dy = longint'(ry) - longint'(ny);
				dz = longint'(rz) - longint'(nz);
				calc = dx * dx + dy * dy + dz * dz;
				checks++;
				if (calc != r2 || int'(calc < longint'(CUTOFF_2)) != pass)
				begin
					$display("trace line for test %0d ids %h/%h disagrees with the cutoff rule",
						tst, rid, nid);
					errors++;
				end
				p = '{ref_id: rid, nbr_id: nid,
					ref_pos: '{x: rx[COORD_W-1:0], y: ry[COORD_W-1:0], z: rz[COORD_W-1:0]},
					nbr_pos: '{x: nx[COORD_W-1:0], y: ny[COORD_W-1:0], z: nz[COORD_W-1:0]}};
				e = '{ref_id: rid, nbr_id: nid, r2: R2_W'(r2),
					dx: DELTA_W'(dx), dy: DELTA_W'(dy), dz: DELTA_W'(dz)};
				t_test.push_back(tst);
				t_gap.push_back(gap);
				t_lane.push_back(lane);
				t_pass.push_back(pass);
				t_pair.push_back(p);
				t_exp.push_back(e);
			end
			$fclose(fd);
			if (t_test.size() == 0)
			begin
				$display("the trace file holds no usable lines");
				errors++;
			end
		end
	endtask

	function automatic bit queues_empty();
		for (int l = 0; l < NUM_LANES; l++)
			if (exp_q[l].size() != 0)
				return 1'b0;
		return 1'b1;
	endfunction

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	initial
	begin
		int i, j, cur, idle, err_start, driven;
		logic [NUM_LANES-1:0] mask;
		in_valid = '0;
		for (int l = 0; l < NUM_LANES; l++)
			in_pair[l] = '0;
		void'($urandom(32'h3f77));
		load_trace();
		loaded = 1;
		wait (arst_n);
		@(posedge clk);
		i = 0;
		while (i < t_test.size())
		begin
			cur = t_test[i];
			err_start = errors;
			driven = 0;
			while (i < t_test.size() && t_test[i] == cur)
			begin
				idle = t_gap[i] - 1;
				if (t_gap[i] > 1)
					idle += $urandom % 3;	// Random idle spacing
				repeat (idle)
				begin
					@(posedge clk);
					in_valid <= '0;
				end
				// Lines with gap 0 share the cycle
				j = i + 1;
				while (j < t_test.size() && t_gap[j] == 0 && t_test[j] == cur)
					j++;
				mask = '0;
				for (int k = i; k < j; k++)
					mask[t_lane[k]] = 1'b1;
				@(negedge clk);
				while ((back_pressure & mask) != '0)
				begin
					@(posedge clk);
					in_valid <= '0;
					@(negedge clk);
				end
				@(posedge clk);
				for (int k = i; k < j; k++)
				begin
					in_pair[t_lane[k]] <= t_pair[k];
					if (t_pass[k] != 0)
					begin
						exp_q[t_lane[k]].push_back(t_exp[k]);
						exp_t[t_lane[k]].push_back($time);
					end
					driven++;
				end
				in_valid <= mask;
				i = j;
			end
			@(posedge clk);
			in_valid <= '0;
			while (!queues_empty())
				@(negedge clk);
			repeat (8) @(negedge clk);	// Let any stray pair show up
			if (cur == 5)
			begin
				checks += 2;
				if (bp_seen != NUM_LANES'(1))
				begin
					$display("mismatch at %0t: back pressure lanes %b, expected only lane 0",
						$time, bp_seen);
					errors++;
				end
				if (back_pressure != '0)
				begin
					$display("mismatch at %0t: back pressure still high after the lanes drained",
						$time);
					errors++;
				end
			end
			tests++;
			$display("test %0d finished, %0d pairs driven, %0d errors", cur, driven,
				errors - err_start);
		end
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	//////////////////////////////
	// Output scoreboard
	//////////////////////////////
	always @(negedge clk)
	begin
		int lane;
		bit full;
		if (arst_n)
		begin
			bp_seen = bp_seen | back_pressure;
			if (!seen_out)
			begin
				checks++;
				if (back_pressure != '0)
				begin
					$display("mismatch at %0t: back pressure high before any output", $time);
					errors++;
				end
			end
			if (out_valid)
			begin
				seen_out = 1;
				lane = -1;
				full = 1;
				for (int l = 0; l < NUM_LANES; l++)
				begin
					if (lane < 0 && exp_q[l].size() != 0 && exp_q[l][0] == out_pair)
						lane = l;
					// Head driven 5 edges ago was waiting in its buffer
					if (exp_q[l].size() == 0 || exp_t[l][0] + 220 > $time)
						full = 0;
				end
				checks++;
				if (lane < 0)
				begin
					$display("mismatch at %0t: pair ref %h nbr %h r2 %0d matches no lane",
						$time, out_pair.ref_id, out_pair.nbr_id, out_pair.r2);
					errors++;
					full_run = 0;
				end
				else
				begin
					void'(exp_q[lane].pop_front());
					void'(exp_t[lane].pop_front());
					if (!full || $time != last_out + 40)
						full_run = 0;
					if (full)
					begin
						checks++;
						for (int h = 0; h < 3; h++)
						begin
							if (h < full_run && hist[h] == lane)
							begin
								$display("mismatch at %0t: lane %0d granted twice in four",
									$time, lane);
								errors++;
							end
						end
						hist[2] = hist[1];
						hist[1] = hist[0];
						hist[0] = lane;
						full_run++;
					end
				end
				last_out = $time;
			end
		end
	end

	// Watchdog sized from the trace length
	initial
	begin
		wait (loaded);
		#(t_test.size() * 40 * 4 + 6000);
		$display("timeout, the run did not finish in time");
		$display("Test failures found");
		$finish;
	end

endmodule

/* sim/clock_gen.sv */
//////////////////////////////
// Clock and reset generator
// 40 ns clock, reset held low for 4 cycles
//////////////////////////////

module clock_gen (
	output logic clk,
	output logic arst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial
	begin
		arst_n = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);	// Release away from the active edge
		arst_n = 1'b1;
	end

endmodule

/* hdl/filter_bank.sv */
//////////////////////////////
// Filter bank
// Parallel cutoff filter lanes with per-lane buffers, a round-robin
// arbiter and a registered output toward the force pipeline
//////////////////////////////

module filter_bank
	import filter_bank_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic [NUM_LANES-1:0] in_valid,
	input pair_in_t in_pair [NUM_LANES],
	output logic out_valid,
	output pair_out_t out_pair,
	output logic [NUM_LANES-1:0] back_pressure
);

	// Filter to buffer
	logic [NUM_LANES-1:0] buf_wr;
	pair_out_t buf_data [NUM_LANES];

	// Buffer to arbiter and output mux
	logic [NUM_LANES-1:0] avail;
	pair_out_t head [NUM_LANES];

	logic [NUM_LANES-1:0] grant;	// Also pops the granted buffer
	pair_out_t sel_pair;

	//////////////////////////////
	// Lanes
	//////////////////////////////
	for (genvar i = 0; i < NUM_LANES; i++)
	begin : g_lane
		pair_filter u_filter (
			.clk (clk),
			.arst_n (arst_n),
			.in_valid (in_valid[i]),
			.in_pair (in_pair[i]),
			.buf_wr (buf_wr[i]),
			.buf_data (buf_data[i])
		);

		pair_buffer u_buffer (
			.clk (clk),
			.arst_n (arst_n),
			.wr (buf_wr[i]),
			.wr_data (buf_data[i]),
			.pop (grant[i]),
			.avail (avail[i]),
			.head (head[i]),
			.near_full (back_pressure[i])
		);
	end

	filter_arbiter u_arbiter (
		.clk (clk),
		.arst_n (arst_n),
		.avail (avail),
		.grant (grant)
	);

	//////////////////////////////
	// Output mux
	//////////////////////////////

	// Grant is one-hot, so the last match is the only match
	always_comb
	begin
		sel_pair = head[0];
		for (int i = 0; i < NUM_LANES; i++)
		begin
			if (grant[i])
				sel_pair = head[i];
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			out_valid <= 1'b0;
		else
			out_valid <= |grant;	// One cycle behind the grant
	end

	// Holds the last pair while idle
	always_ff @(posedge clk)
	begin
		if (|grant)
			out_pair <= sel_pair;
	end

endmodule

/* hdl/filter_arbiter.sv */
//////////////////////////////
// Filter arbiter
// Round-robin one-hot grant over the lanes with a pair waiting
//////////////////////////////

module filter_arbiter
	import filter_bank_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic [NUM_LANES-1:0] avail,
	output logic [NUM_LANES-1:0] grant
);

	logic [LANE_IDX_W-1:0] last;	// Lane that won most recently
	logic [LANE_IDX_W-1:0] win_idx;

	// Search starts one past the last winner and wraps around
	always_comb
	begin
		logic found;
		int idx;
		found = 1'b0;
		idx = 0;
		grant = '0;
		win_idx = last;
		for (int k = 1; k <= NUM_LANES; k++)
		begin
			idx = (int'(last) + k) % NUM_LANES;
			if (!found && avail[idx])
			begin
				grant[idx] = 1'b1;
				win_idx = LANE_IDX_W'(idx);
				found = 1'b1;
			end
		end
	end

	// Pointer only moves when someone wins
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			last <= LANE_IDX_W'(NUM_LANES - 1);	// Lane 0 first after reset
		else if (|grant)
			last <= win_idx;
	end

	//////////////////////////////
	// Checks
	//////////////////////////////
	a_grant_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(grant))
		else $error("filter_arbiter grant not one-hot");

	a_grant_avail: assert property (@(posedge clk) disable iff (!arst_n)
		(grant & ~avail) == '0)
		else $error("filter_arbiter grant on empty lane");

endmodule

/* hdl/pair_buffer.sv */
//////////////////////////////
// Pair buffer
// Show-ahead FIFO holding one lane's passing pairs, with a
// registered near-full flag for source throttling
//////////////////////////////

module pair_buffer
	import filter_bank_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic wr,
	input pair_out_t wr_data,
	input logic pop,
	output logic avail,
	output pair_out_t head,
	output logic near_full
);

	pair_out_t mem [BUF_DEPTH];

	logic [BUF_ADDR_W-1:0] wr_ptr;
	logic [BUF_ADDR_W-1:0] rd_ptr;
	logic [BUF_ADDR_W:0] count;	// One extra bit to tell full from empty
	logic [BUF_ADDR_W:0] count_next;
	logic full;

	assign full = (count == BUF_DEPTH);
	assign avail = (count != '0);
	assign head = mem[rd_ptr];	// Head is valid whenever avail is high

	always_comb
	begin
		count_next = count;
		case ({wr, pop})
			2'b10: count_next = count + 1'b1;
			2'b01: count_next = count - 1'b1;
			default: count_next = count;	// Idle, or write and pop together
		endcase
	end

	//////////////////////////////
	// Pointers and fill level
	//////////////////////////////
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			near_full <= 1'b0;
		end
		else
		begin
			if (wr)
				wr_ptr <= wr_ptr + 1'b1;	// Wraps at BUF_DEPTH
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count_next;
			near_full <= (count_next >= BP_THRESHOLD);
		end
	end

	// Storage
	always_ff @(posedge clk)
	begin
		if (wr)
			mem[wr_ptr] <= wr_data;
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	// Overflow means the source ignored back pressure for too long
	a_no_write_full: assert property (@(posedge clk) disable iff (!arst_n)
		wr |-> !full)
		else $error("pair_buffer write while full");

	// Arbiter must only grant a lane with a pair waiting
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
		pop |-> avail)
		else $error("pair_buffer pop while empty");

endmodule

/* hdl/pair_filter.sv */
//////////////////////////////
// Pair filter
// Three stage distance pipeline for one lane. Drops pairs whose
// squared distance is not below the cutoff
//////////////////////////////

module pair_filter
	import filter_bank_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	input pair_in_t in_pair,
	output logic buf_wr,
	output pair_out_t buf_data
);

	//////////////////////////////
	// Stage 1 displacement
	//////////////////////////////
	logic s1_valid;
	logic [ID_W-1:0] s1_ref_id;
	logic [ID_W-1:0] s1_nbr_id;
	logic signed [DELTA_W-1:0] s1_dx;
	logic signed [DELTA_W-1:0] s1_dy;
	logic signed [DELTA_W-1:0] s1_dz;

	//////////////////////////////
	// Stage 2 squares
	//////////////////////////////
	logic s2_valid;
	logic [ID_W-1:0] s2_ref_id;
	logic [ID_W-1:0] s2_nbr_id;
	logic signed [DELTA_W-1:0] s2_dx;
	logic signed [DELTA_W-1:0] s2_dy;
	logic signed [DELTA_W-1:0] s2_dz;
	logic [SQ_W-1:0] s2_sq_x;
	logic [SQ_W-1:0] s2_sq_y;
	logic [SQ_W-1:0] s2_sq_z;

	// Stage 3 sum, registered into buf_data below
	logic [R2_W-1:0] r2_sum;

	// Valid bits walk the pipe, one per stage
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			buf_wr <= 1'b0;
		end
		else
		begin
			s1_valid <= in_valid;
			s2_valid <= s1_valid;
			buf_wr <= s2_valid && (r2_sum < CUTOFF_2);	// Strictly inside the cutoff
		end
	end

	// Sign extend before subtracting so the difference never wraps
	always_ff @(posedge clk)
	begin
		s1_ref_id <= in_pair.ref_id;
		s1_nbr_id <= in_pair.nbr_id;
		s1_dx <= DELTA_W'(in_pair.ref_pos.x) - DELTA_W'(in_pair.nbr_pos.x);
		s1_dy <= DELTA_W'(in_pair.ref_pos.y) - DELTA_W'(in_pair.nbr_pos.y);
		s1_dz <= DELTA_W'(in_pair.ref_pos.z) - DELTA_W'(in_pair.nbr_pos.z);
	end

	always_ff @(posedge clk)
	begin
		s2_ref_id <= s1_ref_id;
		s2_nbr_id <= s1_nbr_id;
		s2_dx <= s1_dx;
		s2_dy <= s1_dy;
		s2_dz <= s1_dz;
		s2_sq_x <= s1_dx * s1_dx;	// Signed product, always positive
		s2_sq_y <= s1_dy * s1_dy;
		s2_sq_z <= s1_dz * s1_dz;
	end

	always_comb
	begin
		r2_sum = R2_W'(s2_sq_x) + R2_W'(s2_sq_y) + R2_W'(s2_sq_z);
	end

	// Payload is written every cycle, buf_wr says if it counts
	always_ff @(posedge clk)
	begin
		buf_data.ref_id <= s2_ref_id;
		buf_data.nbr_id <= s2_nbr_id;
		buf_data.r2 <= r2_sum;
		buf_data.dx <= s2_dx;
		buf_data.dy <= s2_dy;
		buf_data.dz <= s2_dz;
	end

endmodule

/* hdl/filter_bank_pkg.sv */
//////////////////////////////
// Filter bank package
// Widths, lane count, cutoff and buffer sizing for the pair
// filter bank, plus the pair structs shared by every block
//////////////////////////////

package filter_bank_pkg;

	//////////////////////////////
	// Lanes
	//////////////////////////////
	localparam int NUM_LANES = 4;
	localparam int LANE_IDX_W = $clog2(NUM_LANES);	// Also sizes the arbiter pointer

	//////////////////////////////
	// Data widths
	//////////////////////////////
	localparam int ID_W = 20;	// Particle ID
	localparam int COORD_W = 16;	// Signed fixed point position
	localparam int COORD_FRAC = 8;	// Fraction bits of a coordinate
	localparam int DELTA_W = COORD_W + 1;	// Difference of two coordinates
	localparam int SQ_W = 2 * DELTA_W;	// One squared displacement
	localparam int R2_W = 36;	// Sum of three squares, with headroom

	// 12 units cutoff, squared and scaled to the fixed point grid
	localparam logic [R2_W-1:0] CUTOFF_2 = R2_W'(144) << (2 * COORD_FRAC);

	//////////////////////////////
	// Pipeline and buffering
	//////////////////////////////
	localparam int FILTER_LATENCY = 3;
	localparam int BUF_DEPTH = 16;
	localparam int BUF_ADDR_W = $clog2(BUF_DEPTH);

	// Leaves room for the pairs still in the filter pipe plus one
	// more strobe from the source before it sees the flag
	localparam int BP_THRESHOLD = BUF_DEPTH - FILTER_LATENCY - 1;

	//////////////////////////////
	// Pair types
	//////////////////////////////
	typedef struct packed {
		logic signed [COORD_W-1:0] x;
		logic signed [COORD_W-1:0] y;
		logic signed [COORD_W-1:0] z;
	} vec_t;

	// Candidate pair as it enters a lane
	typedef struct packed {
		logic [ID_W-1:0] ref_id;
		logic [ID_W-1:0] nbr_id;
		vec_t ref_pos;
		vec_t nbr_pos;
	} pair_in_t;

	// Pair inside the cutoff, as sent to the force pipeline
	typedef struct packed {
		logic [ID_W-1:0] ref_id;
		logic [ID_W-1:0] nbr_id;
		logic [R2_W-1:0] r2;
		logic signed [DELTA_W-1:0] dx;	// Reference minus neighbor
		logic signed [DELTA_W-1:0] dy;
		logic signed [DELTA_W-1:0] dz;
	} pair_out_t;

endpackage
